//--- list.f
source/axi3_pkg.sv
source/mem_req_decode.sv
source/axi3_channel_execute.sv
source/mem_resp_result.sv
source/axi3_ram.sv
source/mem_axi3_subsystem.sv
testbench/mem_axi3_subsystem_tb.sv

//--- source/axi3_channel_execute.sv
module axi3_channel_execute #(
    parameter axi3_pkg::axsize_t SIZE = axi3_pkg::SIZE_8BYTES,
    parameter int MEM_ADDR_WID = 12,
    localparam int DATA_BYTES = axi3_pkg::get_word_size(SIZE),
    localparam int DATA_WID = 8 * DATA_BYTES,
    localparam int ADDR_WID = MEM_ADDR_WID + $clog2(DATA_BYTES)
) (
    input  logic                    clk,
    input  logic                    reset,
    // Command from decode
    input  logic                    cmd_valid,
    input  axi3_pkg::opcode_t       cmd_op,
    input  logic [ADDR_WID-1:0]     cmd_addr,
    input  logic [DATA_WID-1:0]     cmd_data,
    // Write address channel
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output logic [ADDR_WID-1:0]     aw_addr,
    output axi3_pkg::axsize_t       aw_size,
    output logic [3:0]              aw_len,
    // Write data channel
    output logic                    w_valid,
    input  logic                    w_ready,
    output logic [DATA_WID-1:0]     w_data,
    output logic [DATA_BYTES-1:0]   w_strb,
    output logic                    w_last,
    // Write response channel
    input  logic                    b_valid,
    output logic                    b_ready,
    input  axi3_pkg::resp_t         b_resp,
    // Read address channel
    output logic                    ar_valid,
    input  logic                    ar_ready,
    output logic [ADDR_WID-1:0]     ar_addr,
    output axi3_pkg::axsize_t       ar_size,
    output logic [3:0]              ar_len,
    // Read data channel
    input  logic                    r_valid,
    output logic                    r_ready,
    input  logic [DATA_WID-1:0]     r_data,
    input  axi3_pkg::resp_t         r_resp,
    input  logic                    r_last,
    // Completion towards the result stage
    output logic                    done,
    output axi3_pkg::opcode_t       done_op,
    output axi3_pkg::resp_t         done_resp,
    output logic [DATA_WID-1:0]     done_data
);
    import axi3_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT_B,
        ST_WAIT_R
    } state_t;

    state_t                state;
    opcode_t               op;
    logic [ADDR_WID-1:0]   addr_q;
    logic [DATA_WID-1:0]   data_q;
    // AW and W may complete in different cycles
    logic                  aw_done;
    logic                  w_done;

    // =========================================================================
    // Transaction FSM
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (cmd_valid) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (op == OP_WRITE) begin
                        if (aw_valid && aw_ready) begin
                            aw_done <= 1'b1;
                        end
                        if (w_valid && w_ready) begin
                            w_done <= 1'b1;
                        end
                        // Both beats taken, now or earlier
                        if ((aw_done || aw_ready) && (w_done || w_ready)) begin
                            state <= ST_WAIT_B;
                        end
                    end else if (ar_ready) begin
                        state <= ST_WAIT_R;
                    end
                end
                ST_WAIT_B: if (b_valid) state <= ST_IDLE;
                ST_WAIT_R: if (r_valid) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Command held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid) begin
            op     <= cmd_op;
            addr_q <= cmd_addr;
            data_q <= cmd_data;
        end
    end

    // Channel outputs
    assign aw_valid = (state == ST_ADDR) && (op == OP_WRITE) && !aw_done;
    assign w_valid  = (state == ST_ADDR) && (op == OP_WRITE) && !w_done;
    assign ar_valid = (state == ST_ADDR) && (op == OP_READ);
    assign aw_addr  = addr_q;
    assign ar_addr  = addr_q;
    assign aw_size  = SIZE;
    assign ar_size  = SIZE;
    // Single beat, full word
    assign aw_len   = 4'd0;
    assign ar_len   = 4'd0;
    assign w_data   = data_q;
    assign w_strb   = '1;
    assign w_last   = 1'b1;
    assign b_ready  = (state == ST_WAIT_B);
    assign r_ready  = (state == ST_WAIT_R);

    // Completion in the cycle of the B or R beat
    assign done      = (b_valid && b_ready) || (r_valid && r_ready);
    assign done_op   = op;
    assign done_resp = (state == ST_WAIT_R) ? r_resp : b_resp;
    assign done_data = r_data;

    // Payload stable while a stalled valid waits for ready
    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));
    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w_data));
    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));
    // Slave closes every read with its only beat
    a_r_last: assert property (@(posedge clk) disable iff (reset)
        r_valid && r_ready |-> r_last);

endmodule : axi3_channel_execute

//--- source/axi3_pkg.sv
package axi3_pkg;

    // =========================================================================
    // AXI3 encodings
    // =========================================================================

    // Transfer size code carried on AxSIZE
    typedef enum logic [2:0] {
        SIZE_1BYTE    = 3'd0,
        SIZE_2BYTES   = 3'd1,
        SIZE_4BYTES   = 3'd2,
        SIZE_8BYTES   = 3'd3,
        SIZE_16BYTES  = 3'd4,
        SIZE_32BYTES  = 3'd5,
        SIZE_64BYTES  = 3'd6,
        SIZE_128BYTES = 3'd7
    } axsize_t;

    // Response code on BRESP and RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // =========================================================================
    // Bridge command kind
    // =========================================================================

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } opcode_t;

    // Bytes per beat for a size code
    function automatic int get_word_size(axsize_t size);
        return 1 << int'(size);
    endfunction

endpackage : axi3_pkg

//--- source/axi3_ram.sv
module axi3_ram #(
    parameter axi3_pkg::axsize_t SIZE = axi3_pkg::SIZE_8BYTES,
    parameter int MEM_ADDR_WID = 12,
    parameter int DEPTH_LOG2 = 8,
    localparam int DATA_BYTES = axi3_pkg::get_word_size(SIZE),
    localparam int DATA_WID = 8 * DATA_BYTES,
    localparam int ADDR_WID = MEM_ADDR_WID + $clog2(DATA_BYTES)
) (
    input  logic                  clk,
    input  logic                  reset,
    // Write address channel
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  logic [ADDR_WID-1:0]   aw_addr,
    input  axi3_pkg::axsize_t     aw_size,
    input  logic [3:0]            aw_len,
    // Write data channel
    input  logic                  w_valid,
    output logic                  w_ready,
    input  logic [DATA_WID-1:0]   w_data,
    input  logic [DATA_BYTES-1:0] w_strb,
    input  logic                  w_last,
    // Write response channel
    output logic                  b_valid,
    input  logic                  b_ready,
    output axi3_pkg::resp_t       b_resp,
    // Read address channel
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  logic [ADDR_WID-1:0]   ar_addr,
    input  axi3_pkg::axsize_t     ar_size,
    input  logic [3:0]            ar_len,
    // Read data channel
    output logic                  r_valid,
    input  logic                  r_ready,
    output logic [DATA_WID-1:0]   r_data,
    output axi3_pkg::resp_t       r_resp,
    output logic                  r_last
);
    import axi3_pkg::*;

    localparam int OFFSET = $clog2(DATA_BYTES);
    localparam int DEPTH  = 2 ** DEPTH_LOG2;

    logic [DATA_WID-1:0]     mem [DEPTH];
    logic [MEM_ADDR_WID-1:0] aw_idx;
    logic [MEM_ADDR_WID-1:0] ar_idx;
    logic                    aw_in_range;
    logic                    ar_in_range;
    logic                    wr_fire;
    logic                    rd_fire;

    // Word index from the byte address
    assign aw_idx      = aw_addr[ADDR_WID-1:OFFSET];
    assign ar_idx      = ar_addr[ADDR_WID-1:OFFSET];
    assign aw_in_range = (aw_idx < DEPTH);
    assign ar_in_range = (ar_idx < DEPTH);

    // Ready while no response is pending
    assign aw_ready = !b_valid;
    assign w_ready  = !b_valid;
    assign ar_ready = !r_valid;
    assign r_last   = 1'b1;

    // Write takes AW and W in one cycle
    assign wr_fire = aw_valid && w_valid && !b_valid;
    assign rd_fire = ar_valid && ar_ready;

    // =========================================================================
    // Response valids
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Word array, out-of-range writes dropped
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b_resp <= aw_in_range ? OKAY : SLVERR;
            if (aw_in_range) begin
                mem[aw_idx[DEPTH_LOG2-1:0]] <= w_data;
            end
        end
        if (rd_fire) begin
            r_resp <= ar_in_range ? OKAY : SLVERR;
            r_data <= ar_in_range ? mem[ar_idx[DEPTH_LOG2-1:0]] : '0;
        end
    end

    // Single-beat full-word traffic only
    a_ax_form: assert property (@(posedge clk) disable iff (reset)
        (aw_valid |-> aw_len == 4'd0 && aw_size == SIZE) and
        (ar_valid |-> ar_len == 4'd0 && ar_size == SIZE));
    a_w_form: assert property (@(posedge clk) disable iff (reset)
        w_valid |-> (&w_strb) && w_last);
    // Master must present AW together with W
    a_aw_with_w: assert property (@(posedge clk) disable iff (reset)
        aw_valid && aw_ready |-> w_valid);

endmodule : axi3_ram

//--- source/mem_axi3_subsystem.sv
module mem_axi3_subsystem #(
    parameter axi3_pkg::axsize_t SIZE = axi3_pkg::SIZE_8BYTES,
    parameter int MEM_ADDR_WID = 12,
    parameter int DEPTH_LOG2 = 8,
    localparam int DATA_BYTES = axi3_pkg::get_word_size(SIZE),
    localparam int DATA_WID = 8 * DATA_BYTES
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  logic                    wr,
    input  logic [MEM_ADDR_WID-1:0] addr,
    input  logic [DATA_WID-1:0]     wr_data,
    output logic                    busy,
    output logic                    ack,
    output logic [DATA_WID-1:0]     rd_data,
    output logic                    error
);
    import axi3_pkg::*;

    localparam int ADDR_WID = MEM_ADDR_WID + $clog2(DATA_BYTES);

    // =========================================================================
    // Stage links
    // =========================================================================
    logic                  cmd_valid;
    opcode_t               cmd_op;
    logic [ADDR_WID-1:0]   cmd_addr;
    logic [DATA_WID-1:0]   cmd_data;
    logic                  done;
    opcode_t               done_op;
    resp_t                 done_resp;
    logic [DATA_WID-1:0]   done_data;

    // AXI3 bus between bridge and RAM
    logic                  aw_valid, aw_ready;
    logic [ADDR_WID-1:0]   aw_addr;
    axsize_t               aw_size;
    logic [3:0]            aw_len;
    logic                  w_valid, w_ready, w_last;
    logic [DATA_WID-1:0]   w_data;
    logic [DATA_BYTES-1:0] w_strb;
    logic                  b_valid, b_ready;
    resp_t                 b_resp;
    logic                  ar_valid, ar_ready;
    logic [ADDR_WID-1:0]   ar_addr;
    axsize_t               ar_size;
    logic [3:0]            ar_len;
    logic                  r_valid, r_ready, r_last;
    logic [DATA_WID-1:0]   r_data;
    resp_t                 r_resp;

    mem_req_decode #(
        .SIZE         (SIZE),
        .MEM_ADDR_WID (MEM_ADDR_WID)
    ) mem_req_decode_inst (
        .*
    );

    axi3_channel_execute #(
        .SIZE         (SIZE),
        .MEM_ADDR_WID (MEM_ADDR_WID)
    ) axi3_channel_execute_inst (
        .*
    );

    mem_resp_result #(
        .SIZE (SIZE)
    ) mem_resp_result_inst (
        .*
    );

    axi3_ram #(
        .SIZE         (SIZE),
        .MEM_ADDR_WID (MEM_ADDR_WID),
        .DEPTH_LOG2   (DEPTH_LOG2)
    ) axi3_ram_inst (
        .*
    );

endmodule : mem_axi3_subsystem

//--- source/mem_req_decode.sv
module mem_req_decode #(
    parameter axi3_pkg::axsize_t SIZE = axi3_pkg::SIZE_8BYTES,
    parameter int MEM_ADDR_WID = 12,
    localparam int DATA_BYTES = axi3_pkg::get_word_size(SIZE),
    localparam int DATA_WID = 8 * DATA_BYTES,
    localparam int ADDR_WID = MEM_ADDR_WID + $clog2(DATA_BYTES)
) (
    input  logic                    clk,
    input  logic                    reset,
    // Client request
    input  logic                    req,
    input  logic                    wr,
    input  logic [MEM_ADDR_WID-1:0] addr,
    input  logic [DATA_WID-1:0]     wr_data,
    // Completion from the result stage
    input  logic                    ack,
    output logic                    busy,
    // Command towards the execute stage
    output logic                    cmd_valid,
    output axi3_pkg::opcode_t       cmd_op,
    output logic [ADDR_WID-1:0]     cmd_addr,
    output logic [DATA_WID-1:0]     cmd_data
);
    import axi3_pkg::*;

    // Byte offset bits below the word address
    localparam int OFFSET = $clog2(DATA_BYTES);

    logic accept;

    // Ack frees the slot for a request in the same cycle
    assign accept = req && (!busy || ack);

    // Busy level and command strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (ack) begin
                busy <= 1'b0;
            end
        end
    end

    // Command payload, word address turned into a byte address
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_op   <= wr ? OP_WRITE : OP_READ;
            cmd_addr <= ADDR_WID'(addr) << OFFSET;
            cmd_data <= wr_data;
        end
    end

    // Only one request in flight until the result stage acks it
    a_req_while_busy: assert property (@(posedge clk) disable iff (reset)
        req |-> (!busy || ack));

endmodule : mem_req_decode

//--- source/mem_resp_result.sv
module mem_resp_result #(
    parameter axi3_pkg::axsize_t SIZE = axi3_pkg::SIZE_8BYTES,
    localparam int DATA_BYTES = axi3_pkg::get_word_size(SIZE),
    localparam int DATA_WID = 8 * DATA_BYTES
) (
    input  logic                clk,
    input  logic                reset,
    // Completion from execute
    input  logic                done,
    input  axi3_pkg::opcode_t   done_op,
    input  axi3_pkg::resp_t     done_resp,
    input  logic [DATA_WID-1:0] done_data,
    // Client response
    output logic                ack,
    output logic [DATA_WID-1:0] rd_data,
    output logic                error
);
    import axi3_pkg::*;

    logic resp_bad;
    logic keep_data;

    // Anything but OKAY counts as a failure
    assign resp_bad  = (done_resp != OKAY);
    // Only a clean read returns data
    assign keep_data = (done_op == OP_READ) && !resp_bad;

    // =========================================================================
    // Acknowledge and status
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            ack   <= 1'b0;
            error <= 1'b0;
        end else begin
            ack <= done;
            if (done) begin
                error <= resp_bad;
            end
        end
    end

    // Read data, zero for writes and errored reads
    always_ff @(posedge clk) begin
        if (done) begin
            rd_data <= keep_data ? done_data : '0;
        end
    end

endmodule : mem_resp_result

//--- testbench/mem_axi3_subsystem_tb.sv
module mem_axi3_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    // Cycle budget per request for the watchdog
    localparam int REQ_CYCLES   = 20;
    localparam int DATA_WID     = 64;
    localparam int MEM_ADDR_WID = 12;

    logic                    clk;
    logic                    reset;
    logic                    req;
    logic                    wr;
    logic [MEM_ADDR_WID-1:0] addr;
    logic [DATA_WID-1:0]     wr_data;
    logic                    busy;
    logic                    ack;
    logic [DATA_WID-1:0]     rd_data;
    logic                    error;

    // Trace contents, one entry per request
    string                   names[$];
    logic                    is_write[$];
    logic [MEM_ADDR_WID-1:0] addrs[$];
    logic [DATA_WID-1:0]     wdata[$];
    logic [DATA_WID-1:0]     exp_data[$];
    logic                    exp_err[$];

    int trace_count = 0;
    int checks      = 0;
    int errors      = 0;
    int req_issued  = 0;
    int acks_seen   = 0;

    mem_axi3_subsystem mem_axi3_subsystem_inst (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .wr      (wr),
        .addr    (addr),
        .wr_data (wr_data),
        .busy    (busy),
        .ack     (ack),
        .rd_data (rd_data),
        .error   (error)
    );

    // ========================================================================
    // Clock
    // ========================================================================
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Compare one value and log a mismatch
    task automatic check_value(input string name, input logic [DATA_WID-1:0] expected,
                               input logic [DATA_WID-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("Requests: %0d, checks: %0d, errors: %0d", req_issued, checks, errors);
    endtask

    // Reads the trace, skipping comments and blank lines
    task automatic load_trace(output bit ok);
        int                      fd;
        int                      n;
        string                   line;
        string                   name;
        string                   op;
        logic [MEM_ADDR_WID-1:0] a;
        logic [DATA_WID-1:0]     d;
        logic [DATA_WID-1:0]     e;
        logic [DATA_WID-1:0]     err;
        ok = 1'b0;
        fd = $fopen("testbench/mem_axi3_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file testbench/mem_axi3_trace.txt");
        end else begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, d, e, err);
                    if (n == 6 && (op == "W" || op == "R")) begin
                        names.push_back(name);
                        is_write.push_back(op == "W");
                        addrs.push_back(a);
                        wdata.push_back(d);
                        exp_data.push_back(e);
                        exp_err.push_back(err[0]);
                    end else if (n > 0) begin
                        errors++;
                        $display("Malformed trace line skipped: %s", line);
                    end
                end
            end
            $fclose(fd);
            if (names.size() == 0) begin
                ok = 1'b0;
                $display("The trace file holds no requests");
            end
            trace_count = names.size();
        end
    endtask

    // One request, entered and left on a falling edge
    task automatic run_request(input int i);
        bit first;
        first      = 1'b1;
        req        = 1'b1;
        wr         = is_write[i];
        addr       = addrs[i];
        wr_data    = wdata[i];
        req_issued++;
        do begin
            @(negedge clk);
            if (first) begin
                req   = 1'b0;
                wr    = 1'b0;
                first = 1'b0;
            end
            // Busy stays up through the ack cycle
            check_value({names[i], " busy"}, 1, busy);
        end while (!ack);
        check_value({names[i], " rd_data"}, exp_data[i], rd_data);
        check_value({names[i], " error"}, exp_err[i], error);
    endtask

    // ========================================================================
    // Stray ack monitor
    // ========================================================================
    always @(negedge clk) begin
        if (!reset && ack) begin
            acks_seen++;
            if (acks_seen > req_issued) begin
                errors++;
                $display("An ack arrived at %0t with no request pending", $time);
            end
        end
    end

    // Watchdog sized from the trace length
    initial begin
        wait (trace_count > 0);
        repeat (trace_count * REQ_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within its cycle budget");
        print_counts();
        $display("Testbench failed");
        $finish;
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        bit ok;
        reset   = 1'b1;
        req     = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        wr_data = '0;
        load_trace(ok);
        if (!ok) begin
            print_counts();
            $display("Testbench failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(negedge clk);
            reset = 1'b0;
            @(negedge clk);
            // Quiet outputs before the first request
            check_value("idle busy", 0, busy);
            check_value("idle ack", 0, ack);
            check_value("idle error", 0, error);
            // Each request starts on the edge that saw the previous ack
            for (int i = 0; i < trace_count; i++) begin
                run_request(i);
            end
            @(negedge clk);
            check_value("final busy", 0, busy);
            check_value("final ack", 0, ack);
            print_counts();
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule : mem_axi3_subsystem_tb

//--- testbench/mem_axi3_trace.txt
# name op(W/R) word_addr(hex) wr_data(hex) exp_rd_data(hex) exp_error(hex)
# Writes expect rd_data 0; word index 0x100 and above is out of range
wr_a W 010 1122334455667788 0 0
rd_a R 010 0 1122334455667788 0
wr_w0 W 000 a5a5a5a5a5a5a5a5 0 0
wr_w255 W 0ff 0123456789abcdef 0 0
wr_w80 W 080 deadbeefcafef00d 0 0
wr_w10_again W 010 5555aaaa5555aaaa 0 0
wr_w01 W 001 0f0f0f0f0f0f0f0f 0 0
rd_w255 R 0ff 0 0123456789abcdef 0
rd_w01 R 001 0 0f0f0f0f0f0f0f0f 0
rd_w80 R 080 0 deadbeefcafef00d 0
rd_w0 R 000 0 a5a5a5a5a5a5a5a5 0
rd_w10 R 010 0 5555aaaa5555aaaa 0
wr_w80_new W 080 8080808080808080 0 0
rd_w80_new R 080 0 8080808080808080 0
wr_oor_100 W 100 ffffffffffffffff 0 1
rd_oor_100 R 100 0 0 1
rd_w0_kept R 000 0 a5a5a5a5a5a5a5a5 0
wr_oor_3ff W 3ff 1111111111111111 0 1
rd_oor_3ff R 3ff 0 0 1
rd_w255_kept R 0ff 0 0123456789abcdef 0
wr_oor_fff W fff 2222222222222222 0 1
rd_oor_fff R fff 0 0 1
wr_oor_180 W 180 3333333333333333 0 1
rd_w80_kept R 080 0 8080808080808080 0
wr_w7f W 07f 7f7f7f7f00000001 0 0
wr_w7f_again W 07f 7f7f7f7f00000002 0 0
rd_w7f R 07f 0 7f7f7f7f00000002 0
rd_w01_again R 001 0 0f0f0f0f0f0f0f0f 0
